// ==== hw/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

	localparam int data_width = 32;

	// instruction field widths
	localparam int opcode_width = 6;
	localparam int sub_op_base_width = 5;
	localparam int sub_op_ls_width = 8;
	localparam int sub_op_jr_width = 5;

	typedef enum logic [opcode_width-1:0] {
		ty_base = 6'b100000,
		addi    = 6'b101000,
		subri   = 6'b101001,
		andi    = 6'b101010,
		ori     = 6'b101100,
		xori    = 6'b101011,
		slti    = 6'b101110,
		sltsi   = 6'b101111,
		movi    = 6'b100010,
		sethi   = 6'b100011,
		lwi     = 6'b000010,
		swi     = 6'b001010,
		lwibi   = 6'b000110,
		swibi   = 6'b001110,
		ty_ls   = 6'b011100,
		ty_b    = 6'b100110,
		ty_j    = 6'b100100,
		ty_jr   = 6'b100101
	} opcode_e;

	// register ALU and shift-immediate subcodes share one field
	typedef enum logic [sub_op_base_width-1:0] {
		add    = 5'b00000,
		sub    = 5'b00001,
		and_op = 5'b00010,
		xor_op = 5'b00011,
		or_op  = 5'b00100,
		slt    = 5'b00110,
		slts   = 5'b00111,
		slli   = 5'b01000,
		srli   = 5'b01001,
		rotri  = 5'b01011,
		sll    = 5'b01100,
		srl    = 5'b01101
	} sub_op_base_e;

	typedef enum logic [sub_op_ls_width-1:0] {
		lw = 8'b00000010,
		sw = 8'b00001010
	} sub_op_ls_e;

	typedef enum logic [sub_op_jr_width-1:0] {
		jral = 5'b00001
	} sub_op_jr_e;

	// the other jump subcode is plain J
	localparam logic sub_op_jal = 1'b1;

endpackage

`default_nettype wire

// ==== hw/ctrl_pkg.sv ====
`default_nettype none

package ctrl_pkg;

	// second ALU operand
	typedef enum logic [2:0] {
		src2_rb_data = 3'd0,
		src2_imm     = 3'd1,
		src2_lswi    = 3'd2,
		src2_lsw     = 3'd3,
		src2_benx    = 3'd4,
		src2_unknown = 3'd7
	} alu_src2_e;

	// immediate width and extension
	typedef enum logic [2:0] {
		ext_imm5_ze  = 3'd0,
		ext_imm15_se = 3'd1,
		ext_imm15_ze = 3'd2,
		ext_imm20_se = 3'd3,
		ext_imm20_hi = 3'd4,
		ext_unknown  = 3'd7
	} imm_extend_e;

	typedef enum logic {
		maddr_alu_result = 1'b0,
		maddr_ra_data    = 1'b1
	} mem_addr_sel_e;

	// lp is the link register
	typedef enum logic {
		wraddr_rt = 1'b0,
		wraddr_lp = 1'b1
	} wr_addr_sel_e;

	typedef enum logic [2:0] {
		wrreg_alu_result = 3'd0,
		wrreg_imm_data   = 3'd1,
		wrreg_mem        = 3'd2,
		wrreg_pc         = 3'd3,
		wrreg_unknown    = 3'd7
	} wr_reg_sel_e;

endpackage

`default_nettype wire

// ==== hw/operand_decoder.sv ====
`timescale 1ns/10ps
`default_nettype none

module operand_decoder
	import isa_pkg::*, ctrl_pkg::*;
(
	input  opcode_e      opcode,
	input  sub_op_base_e sub_op_base,
	input  sub_op_ls_e   sub_op_ls,
	output alu_src2_e    select_alu_src2,
	output imm_extend_e  select_imm_extend
);

	always_comb begin
		select_alu_src2 = src2_unknown;
		select_imm_extend = ext_unknown;
		case (opcode)
			ty_base: begin
				case (sub_op_base)
					add, sub, and_op, or_op, xor_op, slt, slts, srl, sll: begin
						select_alu_src2 = src2_rb_data;
					end
					// shift amount is a 5-bit field
					srli, slli, rotri: begin
						select_alu_src2 = src2_imm;
						select_imm_extend = ext_imm5_ze;
					end
					default: begin
						select_alu_src2 = src2_unknown;
					end
				endcase
			end
			addi, subri, slti, sltsi: begin
				select_alu_src2 = src2_imm;
				select_imm_extend = ext_imm15_se;
			end
			andi, ori, xori: begin
				select_alu_src2 = src2_imm;
				select_imm_extend = ext_imm15_ze;
			end
			// immediate goes straight to write-back, ALU unused
			movi: begin
				select_imm_extend = ext_imm20_se;
			end
			sethi: begin
				select_imm_extend = ext_imm20_hi;
			end
			lwi, swi, lwibi, swibi: begin
				select_alu_src2 = src2_lswi;
			end
			ty_ls: begin
				if (sub_op_ls == lw || sub_op_ls == sw) begin
					select_alu_src2 = src2_lsw;
				end
			end
			ty_b: begin
				select_alu_src2 = src2_benx;
			end
			default: begin
				select_alu_src2 = src2_unknown;
				select_imm_extend = ext_unknown;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== hw/memory_decoder.sv ====
`timescale 1ns/10ps
`default_nettype none

module memory_decoder
	import isa_pkg::*, ctrl_pkg::*;
(
	input  opcode_e       opcode,
	input  sub_op_ls_e    sub_op_ls,
	output mem_addr_sel_e select_mem_addr,
	output logic          do_dm_read,
	output logic          do_dm_write,
	output logic          do_ra_write
);

	always_comb begin
		select_mem_addr = maddr_alu_result;
		do_dm_read = 1'b0;
		do_dm_write = 1'b0;
		do_ra_write = 1'b0;
		case (opcode)
			lwi: begin
				do_dm_read = 1'b1;
			end
			swi: begin
				do_dm_write = 1'b1;
			end
			// before-increment forms use ra as address, then update ra
			lwibi: begin
				select_mem_addr = maddr_ra_data;
				do_dm_read = 1'b1;
				do_ra_write = 1'b1;
			end
			swibi: begin
				select_mem_addr = maddr_ra_data;
				do_dm_write = 1'b1;
				do_ra_write = 1'b1;
			end
			ty_ls: begin
				case (sub_op_ls)
					lw: begin
						do_dm_read = 1'b1;
					end
					sw: begin
						do_dm_write = 1'b1;
					end
					default: begin
						do_dm_read = 1'b0;
						do_dm_write = 1'b0;
					end
				endcase
			end
			default: begin
				select_mem_addr = maddr_alu_result;
				do_dm_read = 1'b0;
				do_dm_write = 1'b0;
				do_ra_write = 1'b0;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== hw/writeback_decoder.sv ====
`timescale 1ns/10ps
`default_nettype none

module writeback_decoder
	import isa_pkg::*, ctrl_pkg::*;
(
	input  opcode_e      opcode,
	input  sub_op_base_e sub_op_base,
	input  sub_op_ls_e   sub_op_ls,
	input  logic         sub_op_j,
	input  sub_op_jr_e   sub_op_jr,
	output wr_addr_sel_e select_write_reg_addr,
	output wr_reg_sel_e  select_write_reg,
	output logic         do_reg_write
);

	always_comb begin
		select_write_reg_addr = wraddr_rt;
		select_write_reg = wrreg_unknown;
		do_reg_write = 1'b0;
		case (opcode)
			ty_base: begin
				case (sub_op_base)
					add, sub, and_op, or_op, xor_op, slt, slts, srl, sll,
					srli, slli, rotri: begin
						select_write_reg = wrreg_alu_result;
						do_reg_write = 1'b1;
					end
					default: begin
						do_reg_write = 1'b0;
					end
				endcase
			end
			addi, subri, andi, ori, xori, slti, sltsi: begin
				select_write_reg = wrreg_alu_result;
				do_reg_write = 1'b1;
			end
			movi, sethi: begin
				select_write_reg = wrreg_imm_data;
				do_reg_write = 1'b1;
			end
			lwi, lwibi: begin
				select_write_reg = wrreg_mem;
				do_reg_write = 1'b1;
			end
			ty_ls: begin
				// sw writes no register
				if (sub_op_ls == lw) begin
					select_write_reg = wrreg_mem;
					do_reg_write = 1'b1;
				end
			end
			ty_j: begin
				// return address into lp
				if (sub_op_j == sub_op_jal) begin
					select_write_reg_addr = wraddr_lp;
					select_write_reg = wrreg_pc;
					do_reg_write = 1'b1;
				end
			end
			ty_jr: begin
				if (sub_op_jr == jral) begin
					select_write_reg = wrreg_pc;
					do_reg_write = 1'b1;
				end
			end
			default: begin
				select_write_reg_addr = wraddr_rt;
				select_write_reg = wrreg_unknown;
				do_reg_write = 1'b0;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== hw/branch_compare.sv ====
`timescale 1ns/10ps
`default_nettype none

module branch_compare
	import isa_pkg::*;
(
	input  logic [data_width-1:0] reg_rt_data,
	input  logic [data_width-1:0] reg_ra_data,
	output logic                  reg_rt_ra_equal,
	output logic                  reg_rt_zero,
	output logic                  reg_rt_negative
);

	// beq/bne
	assign reg_rt_ra_equal = (reg_rt_data == reg_ra_data);

	// beqz/bnez and the signed compares against zero
	assign reg_rt_zero = ~(|reg_rt_data);
	assign reg_rt_negative = reg_rt_data[data_width-1];

endmodule

`default_nettype wire

// ==== hw/controller.sv ====
`timescale 1ns/10ps
`default_nettype none

module controller
	import isa_pkg::*, ctrl_pkg::*;
(
	input  logic                  arst_n,

	input  opcode_e               opcode,
	input  sub_op_base_e          sub_op_base,
	input  sub_op_ls_e            sub_op_ls,
	input  logic                  sub_op_j,
	input  sub_op_jr_e            sub_op_jr,

	output alu_src2_e             select_alu_src2,
	output imm_extend_e           select_imm_extend,
	output mem_addr_sel_e         select_mem_addr,
	output wr_addr_sel_e          select_write_reg_addr,
	output wr_reg_sel_e           select_write_reg,

	output logic                  do_im_read,
	output logic                  do_dm_read,
	output logic                  do_dm_write,
	output logic                  do_reg_write,
	output logic                  do_ra_write,

	input  logic [data_width-1:0] reg_rt_data,
	input  logic [data_width-1:0] reg_ra_data,
	output logic                  reg_rt_ra_equal,
	output logic                  reg_rt_zero,
	output logic                  reg_rt_negative
);

	// no fetch while in reset
	assign do_im_read = arst_n;

	operand_decoder operand_decoder_i (
		.opcode            (opcode),
		.sub_op_base       (sub_op_base),
		.sub_op_ls         (sub_op_ls),
		.select_alu_src2   (select_alu_src2),
		.select_imm_extend (select_imm_extend)
	);

	memory_decoder memory_decoder_i (
		.opcode          (opcode),
		.sub_op_ls       (sub_op_ls),
		.select_mem_addr (select_mem_addr),
		.do_dm_read      (do_dm_read),
		.do_dm_write     (do_dm_write),
		.do_ra_write     (do_ra_write)
	);

	writeback_decoder writeback_decoder_i (
		.opcode                (opcode),
		.sub_op_base           (sub_op_base),
		.sub_op_ls             (sub_op_ls),
		.sub_op_j              (sub_op_j),
		.sub_op_jr             (sub_op_jr),
		.select_write_reg_addr (select_write_reg_addr),
		.select_write_reg      (select_write_reg),
		.do_reg_write          (do_reg_write)
	);

	// flags for branch resolution
	branch_compare branch_compare_i (
		.reg_rt_data     (reg_rt_data),
		.reg_ra_data     (reg_ra_data),
		.reg_rt_ra_equal (reg_rt_ra_equal),
		.reg_rt_zero     (reg_rt_zero),
		.reg_rt_negative (reg_rt_negative)
	);

endmodule

`default_nettype wire

// ==== tb/tb_clock.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_clock #(
	parameter int period = 100
) (
	output logic clock
);

	initial begin
		clock = 1'b0;
		forever #(period / 2) clock = ~clock;
	end

endmodule

`default_nettype wire

// ==== tb/controller_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module controller_tb
	import isa_pkg::*, ctrl_pkg::*;
();

	localparam int num_rows = 36;
	localparam int num_random = 64;
	localparam int timeout_cycles = num_rows + num_random + 20;
	localparam int drive_delay = 10;
	localparam int check_delay = 80;

	logic clock;
	logic arst_n;
	opcode_e opcode;
	sub_op_base_e sub_op_base;
	sub_op_ls_e sub_op_ls;
	logic sub_op_j;
	sub_op_jr_e sub_op_jr;
	logic [data_width-1:0] reg_rt_data;
	logic [data_width-1:0] reg_ra_data;

	alu_src2_e select_alu_src2;
	imm_extend_e select_imm_extend;
	mem_addr_sel_e select_mem_addr;
	wr_addr_sel_e select_write_reg_addr;
	wr_reg_sel_e select_write_reg;
	logic do_im_read;
	logic do_dm_read;
	logic do_dm_write;
	logic do_reg_write;
	logic do_ra_write;
	logic reg_rt_ra_equal;
	logic reg_rt_zero;
	logic reg_rt_negative;

	// stimulus and expected decode per row
	logic [5:0] row_opcode [num_rows];
	logic [4:0] row_base [num_rows];
	logic [7:0] row_ls [num_rows];
	logic row_j [num_rows];
	logic [4:0] row_jr [num_rows];
	alu_src2_e exp_src2 [num_rows];
	imm_extend_e exp_ext [num_rows];
	mem_addr_sel_e exp_maddr [num_rows];
	logic exp_dm_read [num_rows];
	logic exp_dm_write [num_rows];
	logic exp_ra_write [num_rows];
	wr_addr_sel_e exp_waddr [num_rows];
	wr_reg_sel_e exp_wreg [num_rows];
	logic exp_reg_write [num_rows];

	int row_count = 0;
	int cycle_count = 0;

	tb_clock #(.period(100)) clock_i (.clock(clock));

	controller dut_i (
		.arst_n                (arst_n),
		.opcode                (opcode),
		.sub_op_base           (sub_op_base),
		.sub_op_ls             (sub_op_ls),
		.sub_op_j              (sub_op_j),
		.sub_op_jr             (sub_op_jr),
		.select_alu_src2       (select_alu_src2),
		.select_imm_extend     (select_imm_extend),
		.select_mem_addr       (select_mem_addr),
		.select_write_reg_addr (select_write_reg_addr),
		.select_write_reg      (select_write_reg),
		.do_im_read            (do_im_read),
		.do_dm_read            (do_dm_read),
		.do_dm_write           (do_dm_write),
		.do_reg_write          (do_reg_write),
		.do_ra_write           (do_ra_write),
		.reg_rt_data           (reg_rt_data),
		.reg_ra_data           (reg_ra_data),
		.reg_rt_ra_equal       (reg_rt_ra_equal),
		.reg_rt_zero           (reg_rt_zero),
		.reg_rt_negative       (reg_rt_negative)
	);

	task automatic report_failure();
		$display("*** FAILED ***");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_alu_src2(input alu_src2_e actual, input alu_src2_e expected);
		if (actual !== expected) begin
			$display("Error: select_alu_src2 = 0x%0h, expected 0x%0h at %0t", actual, expected, $time);
			report_failure();
		end
	endtask

	task automatic check_imm_extend(input imm_extend_e actual, input imm_extend_e expected);
		if (actual !== expected) begin
			$display("Error: select_imm_extend = 0x%0h, expected 0x%0h at %0t", actual, expected, $time);
			report_failure();
		end
	endtask

	task automatic check_mem_addr(input mem_addr_sel_e actual, input mem_addr_sel_e expected);
		if (actual !== expected) begin
			$display("Error: select_mem_addr = 0x%0h, expected 0x%0h at %0t", actual, expected, $time);
			report_failure();
		end
	endtask

	task automatic check_wr_addr(input wr_addr_sel_e actual, input wr_addr_sel_e expected);
		if (actual !== expected) begin
			$display("Error: select_write_reg_addr = 0x%0h, expected 0x%0h at %0t",
				actual, expected, $time);
			report_failure();
		end
	endtask

	task automatic check_wr_reg(input wr_reg_sel_e actual, input wr_reg_sel_e expected);
		if (actual !== expected) begin
			$display("Error: select_write_reg = 0x%0h, expected 0x%0h at %0t", actual, expected, $time);
			report_failure();
		end
	endtask

	task automatic check_bit(input string name, input logic actual, input logic expected);
		if (actual !== expected) begin
			$display("Error: %s = 0x%0h, expected 0x%0h at %0t", name, actual, expected, $time);
			report_failure();
		end
	endtask

	task automatic add_row(input logic [5:0] op, input logic [4:0] base, input logic [7:0] ls,
		input logic j, input logic [4:0] jr, input alu_src2_e src2, input imm_extend_e ext,
		input mem_addr_sel_e maddr, input logic rd, input logic wr, input logic raw,
		input wr_addr_sel_e waddr, input wr_reg_sel_e wreg, input logic regw);
		row_opcode[row_count] = op;
		row_base[row_count] = base;
		row_ls[row_count] = ls;
		row_j[row_count] = j;
		row_jr[row_count] = jr;
		exp_src2[row_count] = src2;
		exp_ext[row_count] = ext;
		exp_maddr[row_count] = maddr;
		exp_dm_read[row_count] = rd;
		exp_dm_write[row_count] = wr;
		exp_ra_write[row_count] = raw;
		exp_waddr[row_count] = waddr;
		exp_wreg[row_count] = wreg;
		exp_reg_write[row_count] = regw;
		row_count++;
	endtask

	// register write to rt, no memory access
	task automatic add_alu(input logic [5:0] op, input logic [4:0] base, input alu_src2_e src2,
		input imm_extend_e ext, input wr_reg_sel_e wreg);
		add_row(op, base, 8'h00, 1'b0, 5'd0, src2, ext, maddr_alu_result,
			1'b0, 1'b0, 1'b0, wraddr_rt, wreg, 1'b1);
	endtask

	task automatic add_unknown(input logic [5:0] op, input logic [4:0] base, input logic [7:0] ls,
		input logic j, input logic [4:0] jr);
		add_row(op, base, ls, j, jr, src2_unknown, ext_unknown, maddr_alu_result,
			1'b0, 1'b0, 1'b0, wraddr_rt, wrreg_unknown, 1'b0);
	endtask

	task automatic build_table();
		add_alu(ty_base, add, src2_rb_data, ext_unknown, wrreg_alu_result);
		add_alu(ty_base, sub, src2_rb_data, ext_unknown, wrreg_alu_result);
		add_alu(ty_base, and_op, src2_rb_data, ext_unknown, wrreg_alu_result);
		add_alu(ty_base, or_op, src2_rb_data, ext_unknown, wrreg_alu_result);
		add_alu(ty_base, xor_op, src2_rb_data, ext_unknown, wrreg_alu_result);
		add_alu(ty_base, slt, src2_rb_data, ext_unknown, wrreg_alu_result);
		add_alu(ty_base, slts, src2_rb_data, ext_unknown, wrreg_alu_result);
		add_alu(ty_base, srl, src2_rb_data, ext_unknown, wrreg_alu_result);
		add_alu(ty_base, sll, src2_rb_data, ext_unknown, wrreg_alu_result);
		add_alu(ty_base, srli, src2_imm, ext_imm5_ze, wrreg_alu_result);
		add_alu(ty_base, slli, src2_imm, ext_imm5_ze, wrreg_alu_result);
		add_alu(ty_base, rotri, src2_imm, ext_imm5_ze, wrreg_alu_result);
		add_alu(addi, add, src2_imm, ext_imm15_se, wrreg_alu_result);
		add_alu(subri, add, src2_imm, ext_imm15_se, wrreg_alu_result);
		add_alu(slti, add, src2_imm, ext_imm15_se, wrreg_alu_result);
		add_alu(sltsi, add, src2_imm, ext_imm15_se, wrreg_alu_result);
		add_alu(andi, add, src2_imm, ext_imm15_ze, wrreg_alu_result);
		add_alu(ori, add, src2_imm, ext_imm15_ze, wrreg_alu_result);
		add_alu(xori, add, src2_imm, ext_imm15_ze, wrreg_alu_result);
		add_alu(movi, add, src2_unknown, ext_imm20_se, wrreg_imm_data);
		add_alu(sethi, add, src2_unknown, ext_imm20_hi, wrreg_imm_data);
		// loads and stores
		add_row(lwi, add, 8'h00, 1'b0, 5'd0, src2_lswi, ext_unknown, maddr_alu_result,
			1'b1, 1'b0, 1'b0, wraddr_rt, wrreg_mem, 1'b1);
		add_row(swi, add, 8'h00, 1'b0, 5'd0, src2_lswi, ext_unknown, maddr_alu_result,
			1'b0, 1'b1, 1'b0, wraddr_rt, wrreg_unknown, 1'b0);
		add_row(lwibi, add, 8'h00, 1'b0, 5'd0, src2_lswi, ext_unknown, maddr_ra_data,
			1'b1, 1'b0, 1'b1, wraddr_rt, wrreg_mem, 1'b1);
		add_row(swibi, add, 8'h00, 1'b0, 5'd0, src2_lswi, ext_unknown, maddr_ra_data,
			1'b0, 1'b1, 1'b1, wraddr_rt, wrreg_unknown, 1'b0);
		add_row(ty_ls, add, lw, 1'b0, 5'd0, src2_lsw, ext_unknown, maddr_alu_result,
			1'b1, 1'b0, 1'b0, wraddr_rt, wrreg_mem, 1'b1);
		add_row(ty_ls, add, sw, 1'b0, 5'd0, src2_lsw, ext_unknown, maddr_alu_result,
			1'b0, 1'b1, 1'b0, wraddr_rt, wrreg_unknown, 1'b0);
		// control flow
		add_row(ty_b, add, 8'h00, 1'b0, 5'd0, src2_benx, ext_unknown, maddr_alu_result,
			1'b0, 1'b0, 1'b0, wraddr_rt, wrreg_unknown, 1'b0);
		add_row(ty_j, add, 8'h00, sub_op_jal, 5'd0, src2_unknown, ext_unknown, maddr_alu_result,
			1'b0, 1'b0, 1'b0, wraddr_lp, wrreg_pc, 1'b1);
		add_row(ty_jr, add, 8'h00, 1'b0, jral, src2_unknown, ext_unknown, maddr_alu_result,
			1'b0, 1'b0, 1'b0, wraddr_rt, wrreg_pc, 1'b1);
		// undefined codes
		add_unknown(6'b111111, add, 8'h00, 1'b0, 5'd0);
		add_unknown(ty_base, 5'b11111, 8'h00, 1'b0, 5'd0);
		add_unknown(ty_base, 5'b00101, 8'h00, 1'b0, 5'd0);
		add_unknown(ty_ls, add, 8'hff, 1'b0, 5'd0);
		add_unknown(ty_j, add, 8'h00, ~sub_op_jal, 5'd0);
		add_unknown(ty_jr, add, 8'h00, 1'b0, 5'b00000);
	endtask

	task automatic drive_row(input int i);
		opcode = opcode_e'(row_opcode[i]);
		sub_op_base = sub_op_base_e'(row_base[i]);
		sub_op_ls = sub_op_ls_e'(row_ls[i]);
		sub_op_j = row_j[i];
		sub_op_jr = sub_op_jr_e'(row_jr[i]);
	endtask

	task automatic check_row(input int i);
		check_alu_src2(select_alu_src2, exp_src2[i]);
		check_imm_extend(select_imm_extend, exp_ext[i]);
		check_mem_addr(select_mem_addr, exp_maddr[i]);
		check_wr_addr(select_write_reg_addr, exp_waddr[i]);
		check_wr_reg(select_write_reg, exp_wreg[i]);
		check_bit("do_dm_read", do_dm_read, exp_dm_read[i]);
		check_bit("do_dm_write", do_dm_write, exp_dm_write[i]);
		check_bit("do_ra_write", do_ra_write, exp_ra_write[i]);
		check_bit("do_reg_write", do_reg_write, exp_reg_write[i]);
		check_bit("do_im_read", do_im_read, 1'b1);
	endtask

	task automatic apply_operands(input logic [data_width-1:0] rt, input logic [data_width-1:0] ra);
		@(posedge clock);
		#drive_delay;
		reg_rt_data = rt;
		reg_ra_data = ra;
		#check_delay;
		check_bit("reg_rt_ra_equal", reg_rt_ra_equal, (rt ^ ra) == '0);
		check_bit("reg_rt_zero", reg_rt_zero, rt == '0);
		check_bit("reg_rt_negative", reg_rt_negative, $signed(rt) < 0);
	endtask

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_cycles) begin
			$display("Timeout: the run went past %0d clock cycles", timeout_cycles);
			report_failure();
		end
	end

	initial begin
		logic [data_width-1:0] rt_value;
		logic [data_width-1:0] ra_value;
		void'($urandom(37556));
		arst_n = 1'b0;
		opcode = ty_base;
		sub_op_base = add;
		sub_op_ls = lw;
		sub_op_j = 1'b0;
		sub_op_jr = jral;
		reg_rt_data = '0;
		reg_ra_data = '0;
		build_table();
		if (row_count != num_rows) begin
			$display("The decode table holds %0d rows instead of %0d", row_count, num_rows);
			report_failure();
		end
		// no fetch while reset is held
		repeat (4) begin
			@(posedge clock);
			#drive_delay;
			check_bit("do_im_read", do_im_read, 1'b0);
		end
		arst_n = 1'b1;
		#check_delay;
		check_bit("do_im_read", do_im_read, 1'b1);
		for (int i = 0; i < row_count; i++) begin
			@(posedge clock);
			#drive_delay;
			drive_row(i);
			#check_delay;
			check_row(i);
		end
		// roughly one pair in four is forced equal
		repeat (num_random) begin
			rt_value = $urandom;
			ra_value = $urandom;
			if (ra_value[1:0] == 2'b00) begin
				ra_value = rt_value;
			end
			apply_operands(rt_value, ra_value);
		end
		apply_operands(32'h0000_0000, 32'h0000_0000);
		apply_operands(32'h0000_0000, 32'h1234_5678);
		apply_operands(32'h8000_0000, 32'h8000_0000);
		apply_operands(32'hffff_ffff, 32'h7fff_ffff);
		apply_operands(32'h0000_0001, 32'h0000_0001);
		$display("*** PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

// ==== controller.f ====
hw/isa_pkg.sv
hw/ctrl_pkg.sv
hw/operand_decoder.sv
hw/memory_decoder.sv
hw/writeback_decoder.sv
hw/branch_compare.sv
hw/controller.sv
tb/tb_clock.sv
tb/controller_tb.sv
